//--- hw/isaPkg.sv
`default_nettype none

package isaPkg;

	// Major opcodes, instr[31:26]
	localparam logic [5:0] OP_RTYPE = 6'b000000;
	localparam logic [5:0] OP_J     = 6'b000010;
	localparam logic [5:0] OP_BEQ   = 6'b000100;
	localparam logic [5:0] OP_BNE   = 6'b000101;
	localparam logic [5:0] OP_ADDI  = 6'b001000;
	localparam logic [5:0] OP_ADDIU = 6'b001001;
	localparam logic [5:0] OP_SLTI  = 6'b001010;
	localparam logic [5:0] OP_SLTIU = 6'b001011;
	localparam logic [5:0] OP_ANDI  = 6'b001100;
	localparam logic [5:0] OP_ORI   = 6'b001101;
	localparam logic [5:0] OP_XORI  = 6'b001110;
	localparam logic [5:0] OP_LUI   = 6'b001111;
	localparam logic [5:0] OP_LW    = 6'b100011;
	localparam logic [5:0] OP_SW    = 6'b101011;

	// R-type function codes
	localparam logic [5:0] FN_ADD  = 6'b100000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUB  = 6'b100010;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;
	localparam logic [5:0] FN_SLLV = 6'b000100;
	localparam logic [5:0] FN_SRLV = 6'b000110;
	localparam logic [5:0] FN_SRAV = 6'b000111;

	// ALU operations, same encoding as funct so R-type passes straight through
	localparam logic [5:0] ALU_ADD  = FN_ADD;
	localparam logic [5:0] ALU_ADDU = FN_ADDU;
	localparam logic [5:0] ALU_SUB  = FN_SUB;
	localparam logic [5:0] ALU_SUBU = FN_SUBU;
	localparam logic [5:0] ALU_AND  = FN_AND;
	localparam logic [5:0] ALU_OR   = FN_OR;
	localparam logic [5:0] ALU_XOR  = FN_XOR;
	localparam logic [5:0] ALU_NOR  = FN_NOR;
	localparam logic [5:0] ALU_SLT  = FN_SLT;
	localparam logic [5:0] ALU_SLTU = FN_SLTU;
	localparam logic [5:0] ALU_SLLV = FN_SLLV;
	localparam logic [5:0] ALU_SRLV = FN_SRLV;
	localparam logic [5:0] ALU_SRAV = FN_SRAV;
	localparam logic [5:0] ALU_LUI  = 6'b111111;	// No funct counterpart

	// One instruction word, two field layouts
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0]  opcode;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;	// Low 26 bits of this view form the J target
		} i;
	} instrWord_t;

endpackage

`default_nettype wire

//--- hw/cpuPkg.sv
`default_nettype none

package cpuPkg;

	localparam int DATA_WIDTH     = 32;
	localparam int ADDR_WIDTH     = 9;	// Byte address into data/program memory
	localparam int MEM_BYTES      = 1 << ADDR_WIDTH;
	localparam int REG_COUNT      = 32;
	localparam int REG_ADDR_WIDTH = 5;

	// FSM state encoding
	localparam logic [3:0] ST_FETCH    = 4'd0;
	localparam logic [3:0] ST_DECODE   = 4'd1;
	localparam logic [3:0] ST_EXEC_R   = 4'd2;
	localparam logic [3:0] ST_EXEC_I   = 4'd3;
	localparam logic [3:0] ST_WB       = 4'd4;
	localparam logic [3:0] ST_MEM_ADDR = 4'd5;
	localparam logic [3:0] ST_LOAD     = 4'd6;
	localparam logic [3:0] ST_LOAD_WB  = 4'd7;
	localparam logic [3:0] ST_STORE    = 4'd8;
	localparam logic [3:0] ST_BRANCH   = 4'd9;
	localparam logic [3:0] ST_JUMP     = 4'd10;

	// ALU operand B source
	localparam logic [1:0] SRC_B_REG     = 2'd0;
	localparam logic [1:0] SRC_B_SIGNEXT = 2'd1;
	localparam logic [1:0] SRC_B_ZEROEXT = 2'd2;

	// Register write-back source
	localparam logic WB_ALU = 1'b0;
	localparam logic WB_MEM = 1'b1;

	// ALU control class, IMM picks the operation from the opcode
	localparam logic [1:0] ALUCTL_ADD   = 2'd0;
	localparam logic [1:0] ALUCTL_SUB   = 2'd1;
	localparam logic [1:0] ALUCTL_FUNCT = 2'd2;
	localparam logic [1:0] ALUCTL_IMM   = 2'd3;

	// Next PC source, PC_SAME also points MAR back at the PC
	localparam logic [1:0] PC_INC    = 2'd0;
	localparam logic [1:0] PC_BRANCH = 2'd1;
	localparam logic [1:0] PC_JUMP   = 2'd2;
	localparam logic [1:0] PC_SAME   = 2'd3;

endpackage

`default_nettype wire

//--- hw/registerFile.sv
`timescale 1ns/100ps
`default_nettype none

module registerFile import cpuPkg::*; (
	input  wire                       CLK,
	input  wire                       reset,
	input  wire  [REG_ADDR_WIDTH-1:0] readAddrA,
	input  wire  [REG_ADDR_WIDTH-1:0] readAddrB,
	input  wire  [REG_ADDR_WIDTH-1:0] writeAddr,
	input  wire  [DATA_WIDTH-1:0]     writeData,
	input  wire                       writeEnable,
	output logic [DATA_WIDTH-1:0]     readDataA,
	output logic [DATA_WIDTH-1:0]     readDataB
);

	logic [DATA_WIDTH-1:0] regs [1:REG_COUNT-1];	// R0 has no storage

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int idx = 1; idx < REG_COUNT; idx++)
				regs[idx] <= '0;
		end else if (writeEnable && (writeAddr != '0)) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Combinational reads
	assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

`default_nettype wire

//--- hw/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu import isaPkg::*, cpuPkg::*; (
	input  wire  [5:0]            operation,
	input  wire  [DATA_WIDTH-1:0] operandA,
	input  wire  [DATA_WIDTH-1:0] operandB,
	output logic [DATA_WIDTH-1:0] result,
	output logic                  zero
);

	logic [4:0] shiftAmount;	// Variable shifts take rs[4:0]
	logic       lessSigned;
	logic       lessUnsigned;

	assign shiftAmount  = operandA[4:0];
	assign lessSigned   = $signed(operandA) < $signed(operandB);
	assign lessUnsigned = operandA < operandB;

	always_comb begin
		case (operation)
			// Add and subtract wrap, no overflow trap
			ALU_ADD,
			ALU_ADDU: result = operandA + operandB;
			ALU_SUB,
			ALU_SUBU: result = operandA - operandB;

			ALU_AND:  result = operandA & operandB;
			ALU_OR:   result = operandA | operandB;
			ALU_XOR:  result = operandA ^ operandB;
			ALU_NOR:  result = ~(operandA | operandB);

			ALU_SLT:  result = {{(DATA_WIDTH - 1){1'b0}}, lessSigned};
			ALU_SLTU: result = {{(DATA_WIDTH - 1){1'b0}}, lessUnsigned};

			// Shift the rt operand
			ALU_SLLV: result = operandB << shiftAmount;
			ALU_SRLV: result = operandB >> shiftAmount;
			ALU_SRAV: result = $signed(operandB) >>> shiftAmount;

			ALU_LUI:  result = {operandB[15:0], 16'h0000};
			default:  result = '0;
		endcase
	end

	assign zero = (result == '0);	// Used by BEQ/BNE

endmodule

`default_nettype wire

//--- hw/datapath.sv
`timescale 1ns/100ps
`default_nettype none

module datapath import isaPkg::*, cpuPkg::*; (
	input  wire                   CLK,
	input  wire                   reset,
	input  wire                   pcLoad,
	input  wire  [1:0]            pcSel,
	input  wire                   irLoad,
	input  wire                   marLoad,
	input  wire                   mdrLoad,
	input  wire                   regWrite,
	input  wire                   regDstRd,
	input  wire  [1:0]            aluSrcB,
	input  wire  [1:0]            aluCtl,
	input  wire                   wbSel,
	input  wire  [DATA_WIDTH-1:0] memReadData,
	output logic [5:0]            opcode,
	output logic                  aluZero,
	output logic [ADDR_WIDTH-1:0] memAddr,
	output logic [DATA_WIDTH-1:0] memWriteData
);

	instrWord_t              ir;
	logic [ADDR_WIDTH-1:0]   pc;
	logic [ADDR_WIDTH-1:0]   mar;	// Address for every access, shadows PC outside loads/stores
	logic [ADDR_WIDTH-1:0]   pcNext;
	logic [ADDR_WIDTH-1:0]   pcBranch;
	logic [ADDR_WIDTH-1:0]   pcJump;
	logic [DATA_WIDTH-1:0]   mdr;
	logic [DATA_WIDTH-1:0]   regA;
	logic [DATA_WIDTH-1:0]   regB;
	logic [DATA_WIDTH-1:0]   aluOut;
	logic [DATA_WIDTH-1:0]   rfDataA;
	logic [DATA_WIDTH-1:0]   rfDataB;
	logic [DATA_WIDTH-1:0]   signExt;
	logic [DATA_WIDTH-1:0]   zeroExt;
	logic [DATA_WIDTH-1:0]   aluB;
	logic [DATA_WIDTH-1:0]   aluResult;
	logic [DATA_WIDTH-1:0]   writeData;
	logic [REG_ADDR_WIDTH-1:0] writeAddr;
	logic [5:0]              aluOperation;
	logic [25:0]             jumpField;

	assign opcode       = ir.r.opcode;
	assign memAddr      = mar;
	assign memWriteData = regB;
	assign signExt      = {{16{ir.i.imm[15]}}, ir.i.imm};
	assign zeroExt      = {16'h0000, ir.i.imm};
	assign jumpField    = {ir.i.rs, ir.i.rt, ir.i.imm};
	assign pcBranch     = pc + {signExt[ADDR_WIDTH-3:0], 2'b00};	// PC already holds PC+4
	assign pcJump       = {jumpField[ADDR_WIDTH-3:0], 2'b00};
	assign writeAddr    = regDstRd ? ir.r.rd : ir.r.rt;
	assign writeData    = (wbSel == WB_MEM) ? mdr : aluOut;

	always_comb begin
		case (pcSel)
			PC_INC:    pcNext = pc + ADDR_WIDTH'(4);
			PC_BRANCH: pcNext = pcBranch;
			PC_JUMP:   pcNext = pcJump;
			default:   pcNext = pc;
		endcase
	end

	always_comb begin
		case (aluSrcB)
			SRC_B_SIGNEXT: aluB = signExt;
			SRC_B_ZEROEXT: aluB = zeroExt;
			default:       aluB = regB;
		endcase
	end

	// ALU control
	always_comb begin
		case (aluCtl)
			ALUCTL_SUB:   aluOperation = ALU_SUB;
			ALUCTL_FUNCT: aluOperation = ir.r.funct;
			ALUCTL_IMM: begin
				case (ir.i.opcode)
					OP_ADDIU: aluOperation = ALU_ADDU;
					OP_SLTI:  aluOperation = ALU_SLT;
					OP_SLTIU: aluOperation = ALU_SLTU;
					OP_ANDI:  aluOperation = ALU_AND;
					OP_ORI:   aluOperation = ALU_OR;
					OP_XORI:  aluOperation = ALU_XOR;
					OP_LUI:   aluOperation = ALU_LUI;
					default:  aluOperation = ALU_ADD;	// ADDI
				endcase
			end
			default:      aluOperation = ALU_ADD;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			pc  <= '0;
			mar <= '0;
		end else begin
			if (pcLoad)
				pc <= pcNext;
			if (marLoad)
				mar <= aluResult[ADDR_WIDTH-1:0];
			else if (pcLoad)
				mar <= pcNext;
		end
	end

	// Operand and result registers reload every cycle
	always_ff @(posedge CLK) begin
		if (irLoad)
			ir <= memReadData;
		if (mdrLoad)
			mdr <= memReadData;
		regA   <= rfDataA;
		regB   <= rfDataB;
		aluOut <= aluResult;
	end

	registerFile regs (
		.CLK(CLK), .reset(reset),
		.readAddrA(ir.r.rs), .readAddrB(ir.r.rt),
		.writeAddr(writeAddr), .writeData(writeData), .writeEnable(regWrite),
		.readDataA(rfDataA), .readDataB(rfDataB)
	);

	alu alu0 (
		.operation(aluOperation),
		.operandA(regA),
		.operandB(aluB),
		.result(aluResult),
		.zero(aluZero)
	);

endmodule

`default_nettype wire

//--- hw/controlUnit.sv
`timescale 1ns/100ps
`default_nettype none

module controlUnit import isaPkg::*, cpuPkg::*; (
	input  wire        CLK,
	input  wire        reset,
	input  wire  [5:0] opcode,
	input  wire        aluZero,
	input  wire        memDone,
	output logic       pcLoad,
	output logic [1:0] pcSel,
	output logic       irLoad,
	output logic       marLoad,
	output logic       mdrLoad,
	output logic       regWrite,
	output logic       regDstRd,
	output logic [1:0] aluSrcB,
	output logic [1:0] aluCtl,
	output logic       wbSel,
	output logic       memRead,
	output logic       memWrite
);

	logic [3:0] state;
	logic [3:0] nextState;
	logic       logicImm;	// Immediates that are zero-extended

	assign logicImm = (opcode == OP_ANDI) || (opcode == OP_ORI) ||
		(opcode == OP_XORI) || (opcode == OP_LUI);

	always_ff @(posedge CLK) begin
		if (reset)
			state <= ST_FETCH;
		else
			state <= nextState;
	end

	always_comb begin
		nextState = state;
		case (state)
			ST_FETCH:    if (memDone) nextState = ST_DECODE;
			ST_DECODE: begin
				case (opcode)
					OP_RTYPE: nextState = ST_EXEC_R;
					OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
					OP_ANDI, OP_ORI, OP_XORI, OP_LUI: nextState = ST_EXEC_I;
					OP_LW, OP_SW:   nextState = ST_MEM_ADDR;
					OP_BEQ, OP_BNE: nextState = ST_BRANCH;
					OP_J:           nextState = ST_JUMP;
					default:        nextState = ST_FETCH;	// Unsupported, skip it
				endcase
			end
			ST_EXEC_R,
			ST_EXEC_I:   nextState = ST_WB;
			ST_MEM_ADDR: nextState = (opcode == OP_LW) ? ST_LOAD : ST_STORE;
			ST_LOAD:     if (memDone) nextState = ST_LOAD_WB;
			ST_STORE:    if (memDone) nextState = ST_FETCH;
			default:     nextState = ST_FETCH;	// WB, LOAD_WB, BRANCH, JUMP
		endcase
	end

	always_comb begin
		pcLoad   = 1'b0;
		pcSel    = PC_INC;
		irLoad   = 1'b0;
		marLoad  = 1'b0;
		mdrLoad  = 1'b0;
		regWrite = 1'b0;
		regDstRd = 1'b0;
		aluSrcB  = SRC_B_REG;
		aluCtl   = ALUCTL_ADD;
		wbSel    = WB_ALU;
		memRead  = 1'b0;
		memWrite = 1'b0;
		case (state)
			ST_FETCH: begin
				memRead = 1'b1;
				irLoad  = memDone;
				pcLoad  = memDone;	// PC and MAR step to PC+4
			end
			ST_EXEC_R: begin
				aluCtl = ALUCTL_FUNCT;
			end
			ST_EXEC_I: begin
				aluCtl  = ALUCTL_IMM;
				aluSrcB = logicImm ? SRC_B_ZEROEXT : SRC_B_SIGNEXT;
			end
			ST_WB: begin
				regWrite = 1'b1;
				regDstRd = (opcode == OP_RTYPE);
			end
			ST_MEM_ADDR: begin
				aluSrcB = SRC_B_SIGNEXT;	// base + offset into MAR
				marLoad = 1'b1;
			end
			ST_LOAD: begin
				memRead = 1'b1;
				mdrLoad = memDone;
			end
			ST_LOAD_WB: begin
				regWrite = 1'b1;
				wbSel    = WB_MEM;
				pcLoad   = 1'b1;
				pcSel    = PC_SAME;
			end
			ST_STORE: begin
				memWrite = 1'b1;
				pcLoad   = memDone;
				pcSel    = PC_SAME;
			end
			ST_BRANCH: begin
				aluCtl = ALUCTL_SUB;	// Zero flag means rs == rt
				pcSel  = PC_BRANCH;
				pcLoad = (opcode == OP_BEQ) ? aluZero : !aluZero;
			end
			ST_JUMP: begin
				pcLoad = 1'b1;
				pcSel  = PC_JUMP;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hw/mipsCore.sv
`timescale 1ns/100ps
`default_nettype none

module mipsCore import cpuPkg::*; (
	input  wire                   CLK,
	input  wire                   reset,
	input  wire  [DATA_WIDTH-1:0] memReadData,
	input  wire                   memDone,
	output logic [ADDR_WIDTH-1:0] memAddr,
	output logic [DATA_WIDTH-1:0] memWriteData,
	output logic                  memRead,
	output logic                  memWrite
);

	// Control to datapath
	logic       pcLoad;
	logic [1:0] pcSel;
	logic       irLoad;
	logic       marLoad;
	logic       mdrLoad;
	logic       regWrite;
	logic       regDstRd;
	logic [1:0] aluSrcB;
	logic [1:0] aluCtl;
	logic       wbSel;

	// Datapath back to control
	logic [5:0] opcode;
	logic       aluZero;

	controlUnit ctrl (
		.CLK(CLK), .reset(reset),
		.opcode(opcode), .aluZero(aluZero), .memDone(memDone),
		.pcLoad(pcLoad), .pcSel(pcSel),
		.irLoad(irLoad), .marLoad(marLoad), .mdrLoad(mdrLoad),
		.regWrite(regWrite), .regDstRd(regDstRd),
		.aluSrcB(aluSrcB), .aluCtl(aluCtl), .wbSel(wbSel),
		.memRead(memRead), .memWrite(memWrite)
	);

	datapath dp (
		.CLK(CLK), .reset(reset),
		.pcLoad(pcLoad), .pcSel(pcSel),
		.irLoad(irLoad), .marLoad(marLoad), .mdrLoad(mdrLoad),
		.regWrite(regWrite), .regDstRd(regDstRd),
		.aluSrcB(aluSrcB), .aluCtl(aluCtl), .wbSel(wbSel),
		.memReadData(memReadData),
		.opcode(opcode), .aluZero(aluZero),
		.memAddr(memAddr), .memWriteData(memWriteData)
	);

endmodule

`default_nettype wire

//--- verification/mipsCore_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module mipsCore_assertions import cpuPkg::*; (
	input wire                  CLK,
	input wire                  reset,
	input wire                  memRead,
	input wire                  memWrite,
	input wire                  memDone,
	input wire [ADDR_WIDTH-1:0] memAddr
);

	int failCount;	// Failures seen so far, read by the testbench summary

	// One request kind at a time
	noDualRequest: assert property (@(posedge CLK) disable iff (reset)
		!(memRead && memWrite))
		else begin
			$error("memRead and memWrite high together");
			failCount++;
		end

	// Address held until memDone
	addrStable: assert property (@(posedge CLK) disable iff (reset)
		(memRead || memWrite) && !memDone |=> $stable(memAddr))
		else begin
			$error("memAddr changed while a request was pending");
			failCount++;
		end

	wordAligned: assert property (@(posedge CLK) disable iff (reset)
		(memRead || memWrite) |-> (memAddr[1:0] == 2'b00))
		else begin
			$error("memAddr %h is not word aligned", memAddr);
			failCount++;
		end

endmodule

bind mipsCore mipsCore_assertions memPortChecks (
	.CLK(CLK), .reset(reset),
	.memRead(memRead), .memWrite(memWrite),
	.memDone(memDone), .memAddr(memAddr)
);

`default_nettype wire

//--- verification/mipsCoreTb.sv
`timescale 1ns/100ps
`default_nettype none

module mipsCoreTb import cpuPkg::*; ();

	localparam int MEM_WORDS = MEM_BYTES / 4;
	localparam int VEC_WORDS = 128;
	localparam int REC_BASE  = 'h40;	// First store record in the vector file

	logic                  CLK;
	logic                  reset;
	logic [DATA_WIDTH-1:0] memReadData;
	logic                  memDone;
	logic [ADDR_WIDTH-1:0] memAddr;
	logic [DATA_WIDTH-1:0] memWriteData;
	logic                  memRead;
	logic                  memWrite;

	logic [DATA_WIDTH-1:0] vec [0:VEC_WORDS-1];
	logic [DATA_WIDTH-1:0] mem [0:MEM_WORDS-1];	// 512 bytes as words
	logic [ADDR_WIDTH-1:0] storeAddrQ [$];
	logic [DATA_WIDTH-1:0] storeDataQ [$];
	logic [ADDR_WIDTH-1:0] haltAddr;
	int                    progWords;
	int                    cycleLimit;
	int                    cycleCount;
	int                    valueErrors;
	int                    otherErrors;
	int                    waitLeft;
	logic                  pending;	// Request seen but memDone not yet given
	logic                  firstRead;
	logic                  haltSeen;
	logic                  timedOut;
	logic                  inReset;

	mipsCore uut (
		.CLK(CLK), .reset(reset),
		.memReadData(memReadData), .memDone(memDone),
		.memAddr(memAddr), .memWriteData(memWriteData),
		.memRead(memRead), .memWrite(memWrite)
	);

	always #50 CLK = ~CLK;

	task automatic checkAddr(input string name, input logic [ADDR_WIDTH-1:0] actual,
			input logic [ADDR_WIDTH-1:0] expected);
		if (actual !== expected) begin
			$display("ERR %s: got %h, expected %h", name, actual, expected);
			valueErrors++;
		end
	endtask

	task automatic checkData(input string name, input logic [DATA_WIDTH-1:0] actual,
			input logic [DATA_WIDTH-1:0] expected);
		if (actual !== expected) begin
			$display("ERR %s: got %h, expected %h", name, actual, expected);
			valueErrors++;
		end
	endtask

	// Completes the pending access and raises memDone for one cycle
	task automatic serveRequest();
		logic [ADDR_WIDTH-1:0] expAddr;
		logic [DATA_WIDTH-1:0] expData;
		if (memWrite) begin
			if (storeAddrQ.size() == 0) begin
				$display("Unexpected store of %h to address %h after the last record",
					memWriteData, memAddr);
				otherErrors++;
			end else begin
				expAddr = storeAddrQ.pop_front();
				expData = storeDataQ.pop_front();
				checkAddr("store memAddr", memAddr, expAddr);
				checkData("memWriteData", memWriteData, expData);
			end
			mem[memAddr[ADDR_WIDTH-1:2]] = memWriteData;
		end else begin
			if (firstRead) begin
				checkAddr("first fetch memAddr", memAddr, '0);
				firstRead = 1'b0;
			end
			memReadData = mem[memAddr[ADDR_WIDTH-1:2]];
			if (memAddr == haltAddr)
				haltSeen = 1'b1;	// J to itself reached
		end
		memDone = 1'b1;
	endtask

	// Memory model answering after 1 to 4 cycles
	always @(posedge CLK) begin
		inReset = reset;
		cycleCount++;
		if (cycleCount >= cycleLimit)
			timedOut = 1'b1;
		#10;
		if (memDone) begin
			memDone = 1'b0;
			pending = 1'b0;
		end else if (!inReset && !haltSeen && (memRead || memWrite)) begin
			if (!pending) begin
				pending  = 1'b1;
				waitLeft = $urandom % 4;
			end
			if (waitLeft == 0)
				serveRequest();
			else
				waitLeft--;
		end
	end

	initial begin
		int idx;
		int assertErrors;
		CLK         = 1'b0;
		reset       = 1'b1;
		memDone     = 1'b0;
		memReadData = '0;
		pending     = 1'b0;
		firstRead   = 1'b1;
		haltSeen    = 1'b0;
		timedOut    = 1'b0;
		inReset     = 1'b1;
		cycleCount  = 0;
		valueErrors = 0;
		otherErrors = 0;
		waitLeft    = 0;
		void'($urandom(32'h2881a47f));

		for (int i = 0; i < VEC_WORDS; i++)
			vec[i] = '1;
		$readmemh("verification/mipsCoreVectors.txt", vec);
		idx = REC_BASE;
		while (idx < VEC_WORDS - 2 && vec[idx] != '1) begin
			storeAddrQ.push_back(vec[idx][ADDR_WIDTH-1:0]);
			storeDataQ.push_back(vec[idx + 1]);
			idx += 2;
		end
		haltAddr   = vec[idx + 1][ADDR_WIDTH-1:0];	// Follows the end marker
		progWords  = int'(haltAddr[ADDR_WIDTH-1:2]) + 1;
		cycleLimit = progWords * 4 * 8;
		for (int w = 0; w < MEM_WORDS; w++)
			mem[w] = (w < progWords) ? vec[w] : (32'hC0DE0000 | (w << 2));
		$display("Loaded %0d program words, %0d store records, cycle limit %0d",
			progWords, storeAddrQ.size(), cycleLimit);

		repeat (3) @(posedge CLK);
		#10;
		reset = 1'b0;

		wait (haltSeen || timedOut);
		if (timedOut && !haltSeen) begin
			$display("Timeout: halt address %h was not fetched within %0d cycles",
				haltAddr, cycleLimit);
			otherErrors++;
		end
		if (storeAddrQ.size() != 0) begin
			$display("%0d expected stores were never made", storeAddrQ.size());
			otherErrors++;
		end
		assertErrors = uut.memPortChecks.failCount;
		$display("Errors: %0d value mismatches, %0d other failures, %0d assertion failures",
			valueErrors, otherErrors, assertErrors);
		if (valueErrors == 0 && otherErrors == 0 && assertErrors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/mipsCoreVectors.txt
// Words 00-3F: program, one instruction word per line, loaded at byte address 0
// From @40: store address then expected data; FFFFFFFF ends the list, then the halt address
34011234 // 00 ori   $1,$0,0x1234
2002FFFD // 04 addi  $2,$0,-3
3C07A5A5 // 08 lui   $7,0xA5A5
00221820 // 0C add   $3,$1,$2
AC030100 // 10 sw    $3,0x100($0)
00412022 // 14 sub   $4,$2,$1
AC040104 // 18 sw    $4,0x104($0)
00E12825 // 1C or    $5,$7,$1
00A23026 // 20 xor   $6,$5,$2
AC060108 // 24 sw    $6,0x108($0)
00A43024 // 28 and   $6,$5,$4
AC06010C // 2C sw    $6,0x10C($0)
00203027 // 30 nor   $6,$1,$0
AC060110 // 34 sw    $6,0x110($0)
0041302A // 38 slt   $6,$2,$1
AC060114 // 3C sw    $6,0x114($0)
0041302B // 40 sltu  $6,$2,$1
AC060118 // 44 sw    $6,0x118($0)
00273007 // 48 srav  $6,$7,$1
AC06011C // 4C sw    $6,0x11C($0)
00273006 // 50 srlv  $6,$7,$1
AC060120 // 54 sw    $6,0x120($0)
00213004 // 58 sllv  $6,$1,$1
AC060124 // 5C sw    $6,0x124($0)
2C46FFFF // 60 sltiu $6,$2,0xFFFF
AC060128 // 64 sw    $6,0x128($0)
3046F0F0 // 68 andi  $6,$2,0xF0F0
AC06012C // 6C sw    $6,0x12C($0)
38468001 // 70 xori  $6,$2,0x8001
AC060130 // 74 sw    $6,0x130($0)
8C080104 // 78 lw    $8,0x104($0)
21000007 // 7C addi  $0,$8,7
AC080134 // 80 sw    $8,0x134($0)
AC000138 // 84 sw    $0,0x138($0)
10630001 // 88 beq   $3,$3,+1
AC0101FC // 8C sw    $1,0x1FC($0)   skipped
14210001 // 90 bne   $1,$1,+1
AC02013C // 94 sw    $2,0x13C($0)
08000028 // 98 j     0xA0
AC0101FC // 9C sw    $1,0x1FC($0)   skipped
AC070140 // A0 sw    $7,0x140($0)
08000029 // A4 j     0xA4
@40
0100 00001231 // add
0104 FFFFEDC9 // sub
0108 5A5AEDC9 // xor
010C A5A50000 // and
0110 FFFFEDCB // nor
0114 00000001 // slt
0118 00000000 // sltu
011C FFFFFA5A // srav
0120 00000A5A // srlv
0124 23400000 // sllv
0128 00000001 // sltiu, sign-extended immediate
012C 0000F0F0 // andi, zero-extended immediate
0130 FFFF7FFC // xori
0134 FFFFEDC9 // lw reload
0138 00000000 // register 0
013C FFFFFFFD // after beq taken and bne not taken
0140 A5A50000 // after j
FFFFFFFF 000000A4

//--- files.f
hw/isaPkg.sv
hw/cpuPkg.sv
hw/registerFile.sv
hw/alu.sv
hw/datapath.sv
hw/controlUnit.sv
hw/mipsCore.sv
verification/mipsCore_assertions.sv
verification/mipsCoreTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = mipsCoreTb
FILELIST  = files.f
OBJDIR    = obj_dir
LOG       = sim.log
FAIL_MSG  = Test failures found
PASS_MSG  = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
